// File: verilog/cache_pkg.sv
// Shared widths, burst encodings and FSM state types for the cache and memory.
// Only incrementing word-sized bursts are used, with no IDs and no error responses.
package cache_pkg;

    // ------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // One strobe bit per data byte
    localparam int STRB_W = DATA_W / 8;
    // Burst length field, N means N+1 beats
    localparam int LEN_W  = 8;

    // ------------------------------------------------------------------
    // Burst encodings
    // ------------------------------------------------------------------
    localparam logic [1:0] BURST_INCR = 2'b01;
    // 2^2 = 4 bytes per beat
    localparam logic [2:0] SIZE_WORD  = 3'b010;
    localparam logic [1:0] RESP_OKAY  = 2'b00;

    // Cache controller states, write-back states are skipped on a clean miss
    typedef enum logic [2:0] {
        IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP,
        FILL_ADDR,
        FILL_DATA
    } cache_state_t;

    // Backing memory states
    typedef enum logic [1:0] {
        M_IDLE,
        M_WAIT,
        M_READ,
        M_WRITE
    } mem_state_t;

endpackage

// File: verilog/mem_bus_if.sv
// Five-channel burst bus with valid/ready handshakes, no IDs and no error codes.
interface mem_bus_if import cache_pkg::*; ();

    // Write address channel
    logic              awvalid;
    logic              awready;
    logic [ADDR_W-1:0] awaddr;
    logic [LEN_W-1:0]  awlen;
    logic [2:0]        awsize;
    logic [1:0]        awburst;

    // Write data channel
    logic              wvalid;
    logic              wready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wlast;

    // Write response channel
    logic              bvalid;
    logic              bready;
    logic [1:0]        bresp;

    // Read address channel
    logic              arvalid;
    logic              arready;
    logic [ADDR_W-1:0] araddr;
    logic [LEN_W-1:0]  arlen;
    logic [2:0]        arsize;
    logic [1:0]        arburst;

    // Read data channel
    logic              rvalid;
    logic              rready;
    logic [DATA_W-1:0] rdata;
    logic              rlast;

    // Cache side issues bursts
    modport master (
        output awvalid, awaddr, awlen, awsize, awburst,
        output wvalid, wdata, wstrb, wlast,
        output bready,
        output arvalid, araddr, arlen, arsize, arburst,
        output rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rlast
    );

    // Memory side answers them
    modport slave (
        input  awvalid, awaddr, awlen, awsize, awburst,
        input  wvalid, wdata, wstrb, wlast,
        input  bready,
        input  arvalid, araddr, arlen, arsize, arburst,
        input  rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rlast
    );

endinterface

// File: verilog/block_cache.sv
// Single-block write-back cache, CACHE_SIZE words under one tag (power of two, >= 2).
// The processor must hold its request while stall is high and never read and write together.
module block_cache import cache_pkg::*; #(
    parameter int CACHE_SIZE = 128
) (
    input  logic              clk,
    input  logic              rst_n,

    // Processor side
    input  logic [ADDR_W-1:0] address,
    input  logic [DATA_W-1:0] write_data,
    input  logic              read_enable,
    input  logic              write_enable,
    input  logic [STRB_W-1:0] byte_enable,
    output logic [DATA_W-1:0] read_data,
    output logic              stall,

    // Memory side
    mem_bus_if.master         bus
);

    // Word offset bits, then byte offset, then tag
    localparam int OFFS_W  = $clog2(CACHE_SIZE);
    localparam int TAG_LSB = OFFS_W + 2;
    localparam int TAG_W   = ADDR_W - TAG_LSB;

    // Block storage
    logic [DATA_W-1:0] cache_data [CACHE_SIZE];
    logic [TAG_W-1:0]  cache_tag;
    logic              cache_valid;
    logic              cache_dirty;

    cache_state_t      state;
    cache_state_t      next_state;

    // Shared counter for write-back and refill beats
    logic [OFFS_W-1:0] beat_cnt;
    logic              last_beat;

    logic [TAG_W-1:0]  req_tag;
    logic [OFFS_W-1:0] req_index;
    logic              req;
    logic              hit;
    logic              hit_write;
    logic [DATA_W-1:0] be_mask;

    logic              w_fire;
    logic              r_fire;
    logic              fill_done;

    // ------------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------------
    assign req_tag   = address[ADDR_W-1:TAG_LSB];
    assign req_index = address[TAG_LSB-1:2];
    assign req       = read_enable | write_enable;
    assign hit       = cache_valid && (cache_tag == req_tag);

    // Miss in IDLE stalls at once, any other state keeps stalling
    assign stall     = (state != IDLE) || (req && !hit);
    assign hit_write = write_enable && !stall;

    // Combinational read, only meaningful on a hit
    assign read_data = cache_data[req_index];

    // Expand byte enables into a bit mask
    always_comb begin
        for (int i = 0; i < STRB_W; i++) begin
            be_mask[8*i +: 8] = {8{byte_enable[i]}};
        end
    end

    // Bus events
    assign w_fire    = bus.wvalid && bus.wready;
    assign r_fire    = bus.rvalid && bus.rready;
    assign fill_done = r_fire && bus.rlast;
    assign last_beat = (beat_cnt == OFFS_W'(CACHE_SIZE - 1));

    // ------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // Dirty block goes back to memory before the refill
                if (req && !hit) begin
                    next_state = cache_dirty ? WB_ADDR : FILL_ADDR;
                end
            end
            WB_ADDR:   if (bus.awready) next_state = WB_DATA;
            WB_DATA:   if (bus.wready && last_beat) next_state = WB_RESP;
            WB_RESP:   if (bus.bvalid) next_state = FILL_ADDR;
            FILL_ADDR: if (bus.arready) next_state = FILL_DATA;
            FILL_DATA: if (fill_done) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    // ------------------------------------------------------------------
    // Control registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            cache_valid <= 1'b0;
            cache_dirty <= 1'b0;
            beat_cnt    <= '0;
        end else begin
            state <= next_state;

            // Counter sits at zero through each address phase
            if (state == WB_ADDR || state == FILL_ADDR) begin
                beat_cnt <= '0;
            end else if (w_fire || r_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
            end

            // Fresh block is valid and clean
            if (fill_done) begin
                cache_valid <= 1'b1;
                cache_dirty <= 1'b0;
            end else if (hit_write) begin
                cache_dirty <= 1'b1;
            end
        end
    end

    // Data array and tag
    always_ff @(posedge clk) begin
        if (r_fire) begin
            cache_data[beat_cnt] <= bus.rdata;
        end else if (hit_write) begin
            // Merge only the enabled bytes
            cache_data[req_index] <= (cache_data[req_index] & ~be_mask) |
                                     (write_data & be_mask);
        end
        if (fill_done) cache_tag <= req_tag;
    end

    // ------------------------------------------------------------------
    // Bus outputs
    // ------------------------------------------------------------------
    // Write-back of the block currently held
    assign bus.awvalid = (state == WB_ADDR);
    assign bus.awaddr  = {cache_tag, {TAG_LSB{1'b0}}};
    assign bus.awlen   = LEN_W'(CACHE_SIZE - 1);
    assign bus.awsize  = SIZE_WORD;
    assign bus.awburst = BURST_INCR;

    // Counter holds while wready is low, so wdata stays put
    assign bus.wvalid  = (state == WB_DATA);
    assign bus.wdata   = cache_data[beat_cnt];
    // Byte masking already happened inside the cache
    assign bus.wstrb   = '1;
    assign bus.wlast   = (state == WB_DATA) && last_beat;
    assign bus.bready  = (state == WB_RESP);

    // Refill of the requested block, address held by the stalled processor
    assign bus.arvalid = (state == FILL_ADDR);
    assign bus.araddr  = {req_tag, {TAG_LSB{1'b0}}};
    assign bus.arlen   = LEN_W'(CACHE_SIZE - 1);
    assign bus.arsize  = SIZE_WORD;
    assign bus.arburst = BURST_INCR;
    assign bus.rready  = (state == FILL_DATA);

endmodule

// File: verilog/burst_mem.sv
// Word memory of MEM_WORDS words (power of two), addresses wrap; bursts up to CACHE_SIZE beats.
// One burst at a time, writes win over reads, every response is OKAY.
module burst_mem import cache_pkg::*; #(
    parameter int CACHE_SIZE  = 128,
    parameter int MEM_WORDS   = 1024,
    parameter int MEM_LATENCY = 3
) (
    input  logic     clk,
    input  logic     rst_n,
    mem_bus_if.slave bus
);

    localparam int MEM_AW = $clog2(MEM_WORDS);
    localparam int BEAT_W = $clog2(CACHE_SIZE);
    localparam int LAT_W  = $clog2(MEM_LATENCY + 1);

    logic [DATA_W-1:0] mem [MEM_WORDS];

    mem_state_t        state;
    logic [MEM_AW-1:0] ptr;
    logic [BEAT_W-1:0] beats_left;
    logic [LAT_W-1:0]  lat_cnt;
    logic              is_write;
    logic              bvalid_q;
    logic              aw_fire;
    logic              ar_fire;

    // Each word holds its own index
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = DATA_W'(i);
        end
    end

    // Address accepted only when idle with no response pending
    assign bus.awready = (state == M_IDLE) && !bvalid_q && bus.awvalid;
    assign bus.arready = (state == M_IDLE) && !bvalid_q && bus.arvalid && !bus.awvalid;
    assign aw_fire     = bus.awvalid && bus.awready;
    assign ar_fire     = bus.arvalid && bus.arready;

    // Beats stream straight off the pointer, held while rready is low
    assign bus.rvalid  = (state == M_READ);
    assign bus.rdata   = mem[ptr];
    assign bus.rlast   = (state == M_READ) && (beats_left == '0);
    assign bus.wready  = (state == M_WRITE);
    assign bus.bvalid  = bvalid_q;
    assign bus.bresp   = RESP_OKAY;

    // ------------------------------------------------------------------
    // Burst sequencing
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= M_IDLE;
            ptr        <= '0;
            beats_left <= '0;
            lat_cnt    <= '0;
            is_write   <= 1'b0;
            bvalid_q   <= 1'b0;
        end else begin
            if (bvalid_q && bus.bready) bvalid_q <= 1'b0;
            case (state)
                M_IDLE: begin
                    lat_cnt <= '0;
                    if (aw_fire || ar_fire) begin
                        is_write   <= aw_fire;
                        ptr        <= aw_fire ? bus.awaddr[MEM_AW+1:2] : bus.araddr[MEM_AW+1:2];
                        beats_left <= aw_fire ? bus.awlen[BEAT_W-1:0] : bus.arlen[BEAT_W-1:0];
                        state      <= M_WAIT;
                    end
                end
                M_WAIT: begin
                    // Fixed access latency before the first beat
                    lat_cnt <= lat_cnt + 1'b1;
                    if (lat_cnt == LAT_W'(MEM_LATENCY - 1)) begin
                        state <= is_write ? M_WRITE : M_READ;
                    end
                end
                M_READ: begin
                    if (bus.rready) begin
                        ptr        <= ptr + 1'b1;
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == '0) state <= M_IDLE;
                    end
                end
                M_WRITE: begin
                    if (bus.wvalid) begin
                        ptr <= ptr + 1'b1;
                        // Response follows the final beat
                        if (bus.wlast) begin
                            bvalid_q <= 1'b1;
                            state    <= M_IDLE;
                        end
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // Storage write under byte strobes
    always @(posedge clk) begin
        if (state == M_WRITE && bus.wvalid) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (bus.wstrb[b]) mem[ptr][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
        end
    end

endmodule

// File: verilog/cache_top.sv
// Self-contained cache system, single-block cache over a fixed-latency burst memory.
// CACHE_SIZE must be a power of two no larger than 256 words.
module cache_top import cache_pkg::*; #(
    parameter int CACHE_SIZE  = 128,
    parameter int MEM_WORDS   = 1024,
    parameter int MEM_LATENCY = 3
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] address,
    input  logic [DATA_W-1:0] write_data,
    input  logic              read_enable,
    input  logic              write_enable,
    input  logic [STRB_W-1:0] byte_enable,
    output logic [DATA_W-1:0] read_data,
    output logic              stall
);

    // Burst bus between cache and memory
    mem_bus_if mem_bus ();

    block_cache #(
        .CACHE_SIZE (CACHE_SIZE)
    ) u_cache (
        .clk          (clk),
        .rst_n        (rst_n),
        .address      (address),
        .write_data   (write_data),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .byte_enable  (byte_enable),
        .read_data    (read_data),
        .stall        (stall),
        .bus          (mem_bus.master)
    );

    // Burst length bound follows the block size
    burst_mem #(
        .CACHE_SIZE  (CACHE_SIZE),
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mem_bus.slave)
    );

endmodule

// File: sim/cache_sva.sv
// Processor-port and burst-bus protocol checks, bound into block_cache.
module cache_sva import cache_pkg::*; #(
    parameter int CACHE_SIZE = 128
) (
    input logic         clk,
    input logic         rst_n,
    input logic         read_enable,
    input logic         write_enable,
    input logic         stall,
    input cache_state_t state,
    input logic         awvalid,
    input logic         awready,
    input logic         wvalid,
    input logic         wready,
    input logic         wlast,
    input logic         arvalid,
    input logic         arready,
    input logic         rvalid,
    input logic         rready,
    input logic         rlast
);

    // Write beats accepted since the last write address
    int unsigned w_beats;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_beats <= 0;
        end else if (awvalid && awready) begin
            w_beats <= 0;
        end else if (wvalid && wready) begin
            w_beats <= w_beats + 1;
        end
    end

    // Never a read and a write in the same cycle
    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        !(read_enable && write_enable))
        else $error("read_enable and write_enable high together");

    // Valids hold until the handshake
    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");
    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    // Last write beat flagged exactly on beat CACHE_SIZE of the burst
    a_wlast_beat: assert property (@(posedge clk) disable iff (!rst_n)
        wlast == (wvalid && w_beats == CACHE_SIZE - 1))
        else $error("wlast not on the final write-back beat");

    // Refilled block serves the held request in the next cycle
    a_fill_release: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && rready && rlast |=> state == IDLE && !stall)
        else $error("stall still high after the last refill beat");

endmodule

bind block_cache cache_sva #(
    .CACHE_SIZE (CACHE_SIZE)
) u_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .read_enable  (read_enable),
    .write_enable (write_enable),
    .stall        (stall),
    .state        (state),
    .awvalid      (bus.awvalid),
    .awready      (bus.awready),
    .wvalid       (bus.wvalid),
    .wready       (bus.wready),
    .wlast        (bus.wlast),
    .arvalid      (bus.arvalid),
    .arready      (bus.arready),
    .rvalid       (bus.rvalid),
    .rready       (bus.rready),
    .rlast        (bus.rlast)
);

// File: sim/cache_tb.sv
// Random read/write traffic against a memory model, addresses confined to MEM_WORDS.
// Stops at the first mismatch; a watchdog bounds the run.
module cache_tb import cache_pkg::*; ();

    localparam int     CACHE_SIZE   = 128;
    localparam int     MEM_WORDS    = 1024;
    localparam int     MEM_LATENCY  = 3;
    localparam int     CLK_PERIOD   = 100;
    localparam int     RESET_CYCLES = 8;
    localparam int     SEED         = 16604;
    localparam int     NUM_ITER     = 100;
    // Three requests per iteration plus the directed eviction sequence
    localparam int     NUM_REQ      = 3 * NUM_ITER + 9;
    localparam int     OFFS_W       = $clog2(CACHE_SIZE);
    localparam int     MEM_AW       = $clog2(MEM_WORDS);
    localparam int     BLK_W        = MEM_AW - OFFS_W;
    // Dirty write-back plus refill, with handshake overhead
    localparam int     MISS_CYCLES  = 2 * (CACHE_SIZE + MEM_LATENCY + 4);
    localparam longint TIMEOUT      =
        longint'(RESET_CYCLES + NUM_REQ * (MISS_CYCLES + 2) + 100) * CLK_PERIOD;

    logic              clk = 1'b0;
    logic              rst_n;
    logic [ADDR_W-1:0] address;
    logic [DATA_W-1:0] write_data;
    logic              read_enable;
    logic              write_enable;
    logic [STRB_W-1:0] byte_enable;
    logic [DATA_W-1:0] read_data;
    logic              stall;

    // Memory mirror and the block the cache should hold
    logic [DATA_W-1:0] mem_model [MEM_WORDS];
    bit                model_valid;
    logic [BLK_W-1:0]  model_block;
    int                errors;

    cache_top #(
        .CACHE_SIZE  (CACHE_SIZE),
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .address      (address),
        .write_data   (write_data),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .byte_enable  (byte_enable),
        .read_data    (read_data),
        .stall        (stall)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Half the picks stay in the held block so hits show up
    function automatic logic [MEM_AW-1:0] pick_word();
        if (model_valid && $urandom_range(1, 0) == 0) begin
            return {model_block, OFFS_W'($urandom_range(CACHE_SIZE - 1, 0))};
        end
        return MEM_AW'($urandom_range(MEM_WORDS - 1, 0));
    endfunction

    // One request, held until stall drops, then checked or merged into the model
    task automatic issue_request(input logic [MEM_AW-1:0] word, input bit is_write,
                                 input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] be);
        logic [DATA_W-1:0] mask;
        logic [BLK_W-1:0]  block;
        block = word[MEM_AW-1:OFFS_W];
        @(posedge clk);
        address      <= ADDR_W'(word) << 2;
        write_data   <= data;
        read_enable  <= !is_write;
        write_enable <= is_write;
        byte_enable  <= be;
        @(negedge clk);
        // Held valid block never stalls, any other block must
        check_value("stall", DATA_W'(!(model_valid && model_block == block)), DATA_W'(stall));
        while (stall) @(negedge clk);
        model_valid = 1'b1;
        model_block = block;
        if (is_write) begin
            for (int i = 0; i < STRB_W; i++) begin
                mask[8*i +: 8] = {8{be[i]}};
            end
            // Lands at the coming edge
            mem_model[word] = (mem_model[word] & ~mask) | (data & mask);
        end else begin
            check_value("read_data", mem_model[word], read_data);
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        logic [MEM_AW-1:0] word;
        void'($urandom(SEED));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = DATA_W'(i);
        end
        model_valid  = 1'b0;
        model_block  = '0;
        errors       = 0;
        rst_n        = 1'b0;
        address      = '0;
        write_data   = '0;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        byte_enable  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("stall", '0, DATA_W'(stall));

        // Random read, then a masked write and its read-back
        for (int n = 0; n < NUM_ITER; n++) begin
            issue_request(pick_word(), 1'b0, '0, '0);
            word = pick_word();
            issue_request(word, 1'b1, $urandom(), STRB_W'($urandom()));
            issue_request(word, 1'b0, '0, '0);
        end

        // Dirty one block, evict it, read it back through memory
        for (int k = 0; k < 4; k++) begin
            issue_request({BLK_W'(3), OFFS_W'(k * 9)}, 1'b1, $urandom(), '1);
        end
        issue_request({BLK_W'(6), OFFS_W'(17)}, 1'b0, '0, '0);
        for (int k = 0; k < 4; k++) begin
            issue_request({BLK_W'(3), OFFS_W'(k * 9)}, 1'b0, '0, '0);
        end

        @(posedge clk);
        read_enable  <= 1'b0;
        write_enable <= 1'b0;
        @(posedge clk);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Bound on total run time, every request taken as a dirty miss
    initial begin
        #(TIMEOUT);
        $display("Timeout: the cache stalled too long, run not done after %0d cycles",
                 TIMEOUT / CLK_PERIOD);
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: flist.f
verilog/cache_pkg.sv
verilog/mem_bus_if.sv
verilog/block_cache.sv
verilog/burst_mem.sv
verilog/cache_top.sv
sim/cache_sva.sv
sim/cache_tb.sv

// File: run.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module cache_tb -f flist.f -o Vcache_tb
./obj_dir/Vcache_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "Simulation ended without a pass result"
    exit 1
fi
echo "Simulation finished cleanly"
